// File: logic/noc_defines.svh
`ifndef NOC_DEFINES_SVH
`define NOC_DEFINES_SVH

// number of virtual channels on one link.
`define NOC_VC_NUM 2

// bits needed to name a virtual channel.
`define NOC_VC_SIZE 1

// flits held by each VC FIFO.
`define NOC_BUFFER_SIZE 4

// width of one mesh coordinate.
`define NOC_COORD_W 2

// head flit payload bits left after the destination.
`define NOC_PAYLOAD_W 12

`endif

// File: logic/noc_flit_pkg.sv
`default_nettype none
`include "noc_defines.svh"

package noc_flit_pkg;

    typedef enum logic [1:0] {HEAD, BODY, TAIL, HEADTAIL} flit_label_t;

    typedef logic [`NOC_VC_SIZE-1:0] vc_id_t;

    // destination sits in the top bits of a head flit.
    typedef struct packed {
        logic [`NOC_COORD_W-1:0]   x_dest;
        logic [`NOC_COORD_W-1:0]   y_dest;
        logic [`NOC_PAYLOAD_W-1:0] payload;
    } head_data_t;

    typedef union packed {
        head_data_t                                head_data;
        logic [2*`NOC_COORD_W+`NOC_PAYLOAD_W-1:0] raw;
    } flit_data_t;

    typedef struct packed {
        flit_label_t flit_label;
        flit_data_t  data;
    } flit_novc_t;

    typedef struct packed {
        flit_label_t flit_label;
        vc_id_t      vc_id;
        flit_data_t  data;
    } flit_t;

endpackage

`default_nettype wire

// File: logic/noc_route_pkg.sv
`default_nettype none
`include "noc_defines.svh"

package noc_route_pkg;

    typedef logic [`NOC_COORD_W-1:0] coord_t;

    // output ports of a mesh router.
    typedef enum logic [2:0] {
        LOCAL,
        NORTH,
        SOUTH,
        EAST,
        WEST
    } port_t;

    // per-packet life of one virtual channel.
    typedef enum logic [1:0] {
        IDLE,
        VC_ALLOC,
        ACTIVE
    } vc_state_t;

endpackage

`default_nettype wire

// File: logic/vc_buffer_if.sv
`timescale 1ns/1ps
`default_nettype none

interface vc_buffer_if;

    // driven by the input port control.
    logic                     write;
    logic                     read;
    noc_flit_pkg::flit_novc_t data;
    noc_route_pkg::port_t     out_port;

    // driven by the VC buffer.
    logic                     is_full;
    logic                     is_empty;
    logic                     on_off;
    logic                     vc_request;
    logic                     switch_request;
    noc_route_pkg::port_t     head_out_port;
    noc_flit_pkg::vc_id_t     downstream_vc;
    noc_flit_pkg::flit_novc_t flit;

    modport ctrl (
        output write, read, data, out_port,
        input  is_full, is_empty, on_off, vc_request, switch_request,
        input  head_out_port, downstream_vc, flit
    );

    modport buffer (
        input  write, read, data, out_port,
        output is_full, is_empty, on_off, vc_request, switch_request,
        output head_out_port, downstream_vc, flit
    );

endinterface

`default_nettype wire

// File: logic/route_compute.sv
`timescale 1ns/1ps
`default_nettype none

module route_compute #(
    parameter int X_CURRENT = 1,
    parameter int Y_CURRENT = 1
)(
    input  wire noc_route_pkg::coord_t x_dest_i,
    input  wire noc_route_pkg::coord_t y_dest_i,
    output noc_route_pkg::port_t       out_port_o
);

    localparam noc_route_pkg::coord_t X_HERE = noc_route_pkg::coord_t'(X_CURRENT);
    localparam noc_route_pkg::coord_t Y_HERE = noc_route_pkg::coord_t'(Y_CURRENT);

    // x first, then y.
    always_comb
    begin
        if (x_dest_i > X_HERE)
            out_port_o = noc_route_pkg::EAST;
        else if (x_dest_i < X_HERE)
            out_port_o = noc_route_pkg::WEST;
        else if (y_dest_i > Y_HERE)
            out_port_o = noc_route_pkg::SOUTH;
        else if (y_dest_i < Y_HERE)
            out_port_o = noc_route_pkg::NORTH;
        else
            out_port_o = noc_route_pkg::LOCAL;
    end

endmodule

`default_nettype wire

// File: logic/vc_buffer.sv
`timescale 1ns/1ps
`default_nettype none
`include "noc_defines.svh"

module vc_buffer (
    input  wire                       clk,
    input  wire                       reset_i,
    input  wire noc_flit_pkg::vc_id_t vc_new_i,
    input  wire                       vc_valid_i,
    vc_buffer_if.buffer               port,
    output logic                      error_o
);

    typedef logic [$clog2(`NOC_BUFFER_SIZE)-1:0]   ptr_t;
    typedef logic [$clog2(`NOC_BUFFER_SIZE+1)-1:0] count_t;

    // flit storage, with the route computed when each flit came in.
    noc_flit_pkg::flit_novc_t flit_mem [`NOC_BUFFER_SIZE];
    noc_route_pkg::port_t     port_mem [`NOC_BUFFER_SIZE];

    ptr_t   wr_ptr;
    ptr_t   rd_ptr;
    count_t count;

    noc_route_pkg::vc_state_t state;
    noc_route_pkg::vc_state_t state_next;
    noc_route_pkg::port_t     route_q;
    noc_flit_pkg::vc_id_t     downstream_vc_q;

    logic front_is_head;
    logic front_is_tail;
    logic push;
    logic pop;
    logic drop;

    function automatic ptr_t next_ptr(input ptr_t p);
        if (p == ptr_t'(`NOC_BUFFER_SIZE - 1))
            return '0;
        return p + 1'b1;
    endfunction

    assign front_is_head = (port.flit.flit_label == noc_flit_pkg::HEAD) ||
                           (port.flit.flit_label == noc_flit_pkg::HEADTAIL);
    assign front_is_tail = (port.flit.flit_label == noc_flit_pkg::TAIL) ||
                           (port.flit.flit_label == noc_flit_pkg::HEADTAIL);

    // a stray body or tail at the front of an idle VC is thrown away.
    assign drop = (state == noc_route_pkg::IDLE) && !port.is_empty && !front_is_head;
    assign push = port.write && !port.is_full;
    assign pop  = (port.read && !port.is_empty) || drop;

    always_ff @(posedge clk)
    begin
        if (push)
        begin
            flit_mem[wr_ptr] <= port.data;
            port_mem[wr_ptr] <= port.out_port;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset_i)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= next_ptr(wr_ptr);
            if (pop)
                rd_ptr <= next_ptr(rd_ptr);
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_comb
    begin
        state_next = state;
        case (state)
            noc_route_pkg::IDLE:
                if (!port.is_empty && front_is_head)
                    state_next = noc_route_pkg::VC_ALLOC;
            noc_route_pkg::VC_ALLOC:
                if (vc_valid_i)
                    state_next = noc_route_pkg::ACTIVE;
            noc_route_pkg::ACTIVE:
                if (port.read && !port.is_empty && front_is_tail)
                    state_next = noc_route_pkg::IDLE;
            default:
                state_next = noc_route_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset_i)
        begin
            state   <= noc_route_pkg::IDLE;
            error_o <= 1'b0;
        end
        else
        begin
            state   <= state_next;
            error_o <= (port.write && port.is_full) || (port.read && port.is_empty) || drop;
        end
    end

    // route and downstream VC stay fixed for the whole packet.
    always_ff @(posedge clk)
    begin
        if (state == noc_route_pkg::IDLE && state_next == noc_route_pkg::VC_ALLOC)
            route_q <= port_mem[rd_ptr];
        if (state == noc_route_pkg::VC_ALLOC && vc_valid_i)
            downstream_vc_q <= vc_new_i;
    end

    assign port.is_full        = (count == count_t'(`NOC_BUFFER_SIZE));
    assign port.is_empty       = (count == '0);
    assign port.on_off         = (count < count_t'(`NOC_BUFFER_SIZE - 1));
    assign port.vc_request     = (state == noc_route_pkg::VC_ALLOC);
    assign port.switch_request = (state == noc_route_pkg::ACTIVE) && !port.is_empty;
    assign port.head_out_port  = route_q;
    assign port.downstream_vc  = downstream_vc_q;
    assign port.flit           = flit_mem[rd_ptr];

    // the switch arbiter must never pick a VC with nothing stored.
    a_no_read_empty: assert property (@(posedge clk) disable iff (reset_i)
        port.read |-> !port.is_empty);

    // the head waits in place until the allocator answers.
    a_alloc_not_empty: assert property (@(posedge clk) disable iff (reset_i)
        state == noc_route_pkg::VC_ALLOC |-> !port.is_empty);

endmodule

`default_nettype wire

// File: logic/switch_arbiter.sv
`timescale 1ns/1ps
`default_nettype none
`include "noc_defines.svh"

module switch_arbiter (
    input  wire                   clk,
    input  wire                   reset_i,
    input  wire [`NOC_VC_NUM-1:0] switch_request_i,
    input  wire                   xbar_ready_i,
    output noc_flit_pkg::vc_id_t  vc_sel_o,
    output logic                  valid_sel_o
);

    noc_flit_pkg::vc_id_t prio_q;

    // search from the priority pointer and wrap around.
    always_comb
    begin
        int unsigned idx;
        logic        found;
        found    = 1'b0;
        vc_sel_o = prio_q;
        for (int i = 0; i < `NOC_VC_NUM; i++)
        begin
            idx = (int'(prio_q) + i) % `NOC_VC_NUM;
            if (!found && switch_request_i[idx])
            begin
                found    = 1'b1;
                vc_sel_o = noc_flit_pkg::vc_id_t'(idx);
            end
        end
        valid_sel_o = found && xbar_ready_i;
    end

    // winner drops to lowest priority.
    always_ff @(posedge clk)
    begin
        if (reset_i)
            prio_q <= '0;
        else if (valid_sel_o)
            prio_q <= noc_flit_pkg::vc_id_t'((int'(vc_sel_o) + 1) % `NOC_VC_NUM);
    end

    // with others waiting, the last winner does not win twice in a row.
    a_winner_yields: assert property (@(posedge clk) disable iff (reset_i)
        $past(valid_sel_o) && valid_sel_o && ($countones(switch_request_i) > 1)
        |-> vc_sel_o != $past(vc_sel_o));

endmodule

`default_nettype wire

// File: logic/input_port.sv
`timescale 1ns/1ps
`default_nettype none
`include "noc_defines.svh"

module input_port #(
    parameter int X_CURRENT = 1,
    parameter int Y_CURRENT = 1
)(
    input  wire                                         clk,
    input  wire                                         reset_i,
    input  wire noc_flit_pkg::flit_t                    data_i,
    input  wire                                         valid_flit_i,
    input  wire noc_flit_pkg::vc_id_t [`NOC_VC_NUM-1:0] vc_new_i,
    input  wire [`NOC_VC_NUM-1:0]                       vc_valid_i,
    input  wire noc_flit_pkg::vc_id_t                   vc_sel_i,
    input  wire                                         valid_sel_i,
    output noc_flit_pkg::flit_t                         flit_o,
    output noc_route_pkg::port_t                        out_port_o,
    output logic [`NOC_VC_NUM-1:0]                      switch_request_o,
    output logic [`NOC_VC_NUM-1:0]                      vc_request_o,
    output logic [`NOC_VC_NUM-1:0]                      on_off_o,
    output logic [`NOC_VC_NUM-1:0]                      is_full_o,
    output logic [`NOC_VC_NUM-1:0]                      is_empty_o,
    output logic [`NOC_VC_NUM-1:0]                      error_o
);

    noc_flit_pkg::flit_novc_t data_novc;
    noc_route_pkg::port_t     route_in;

    // per-VC front of queue, gathered for the output mux.
    noc_flit_pkg::flit_novc_t vc_flit       [`NOC_VC_NUM];
    noc_route_pkg::port_t     vc_route      [`NOC_VC_NUM];
    noc_flit_pkg::vc_id_t     vc_downstream [`NOC_VC_NUM];

    assign data_novc = '{flit_label: data_i.flit_label, data: data_i.data};

    route_compute #(
        .X_CURRENT(X_CURRENT),
        .Y_CURRENT(Y_CURRENT)
    ) route_compute_i (
        .x_dest_i  (data_i.data.head_data.x_dest),
        .y_dest_i  (data_i.data.head_data.y_dest),
        .out_port_o(route_in)
    );

    for (genvar vc = 0; vc < `NOC_VC_NUM; vc++)
    begin : g_vc
        vc_buffer_if vc_if ();

        // write by the flit's own tag, read by the arbiter's pick.
        assign vc_if.write    = valid_flit_i && (data_i.vc_id == noc_flit_pkg::vc_id_t'(vc));
        assign vc_if.read     = valid_sel_i && (vc_sel_i == noc_flit_pkg::vc_id_t'(vc));
        assign vc_if.data     = data_novc;
        assign vc_if.out_port = route_in;

        vc_buffer vc_buffer_i (
            .clk       (clk),
            .reset_i   (reset_i),
            .vc_new_i  (vc_new_i[vc]),
            .vc_valid_i(vc_valid_i[vc]),
            .port      (vc_if.buffer),
            .error_o   (error_o[vc])
        );

        assign vc_flit[vc]          = vc_if.flit;
        assign vc_route[vc]         = vc_if.head_out_port;
        assign vc_downstream[vc]    = vc_if.downstream_vc;
        assign switch_request_o[vc] = vc_if.switch_request;
        assign vc_request_o[vc]     = vc_if.vc_request;
        assign on_off_o[vc]         = vc_if.on_off;
        assign is_full_o[vc]        = vc_if.is_full;
        assign is_empty_o[vc]       = vc_if.is_empty;
    end

    // the outgoing flit carries the downstream VC instead of the local one.
    always_comb
    begin
        flit_o.flit_label = vc_flit[vc_sel_i].flit_label;
        flit_o.vc_id      = vc_downstream[vc_sel_i];
        flit_o.data       = vc_flit[vc_sel_i].data;
        out_port_o        = vc_route[vc_sel_i];
    end

endmodule

`default_nettype wire

// File: logic/router_input_stage.sv
`timescale 1ns/1ps
`default_nettype none
`include "noc_defines.svh"

module router_input_stage #(
    parameter int X_CURRENT = 1,
    parameter int Y_CURRENT = 1
)(
    input  wire                                         clk,
    input  wire                                         reset_i,
    input  wire noc_flit_pkg::flit_t                    data_i,
    input  wire                                         valid_flit_i,
    input  wire [`NOC_VC_NUM-1:0]                       vc_valid_i,
    input  wire noc_flit_pkg::vc_id_t [`NOC_VC_NUM-1:0] vc_new_i,
    input  wire                                         xbar_ready_i,
    output noc_flit_pkg::flit_t                         flit_o,
    output logic                                        flit_valid_o,
    output noc_route_pkg::port_t                        out_port_o,
    output logic [`NOC_VC_NUM-1:0]                      vc_request_o,
    output logic [`NOC_VC_NUM-1:0]                      on_off_o,
    output logic [`NOC_VC_NUM-1:0]                      is_full_o,
    output logic [`NOC_VC_NUM-1:0]                      is_empty_o,
    output logic [`NOC_VC_NUM-1:0]                      error_o
);

    logic [`NOC_VC_NUM-1:0] switch_request;
    noc_flit_pkg::vc_id_t   vc_sel;
    logic                   valid_sel;

    input_port #(
        .X_CURRENT(X_CURRENT),
        .Y_CURRENT(Y_CURRENT)
    ) input_port_i (
        .clk             (clk),
        .reset_i         (reset_i),
        .data_i          (data_i),
        .valid_flit_i    (valid_flit_i),
        .vc_new_i        (vc_new_i),
        .vc_valid_i      (vc_valid_i),
        .vc_sel_i        (vc_sel),
        .valid_sel_i     (valid_sel),
        .flit_o          (flit_o),
        .out_port_o      (out_port_o),
        .switch_request_o(switch_request),
        .vc_request_o    (vc_request_o),
        .on_off_o        (on_off_o),
        .is_full_o       (is_full_o),
        .is_empty_o      (is_empty_o),
        .error_o         (error_o)
    );

    switch_arbiter switch_arbiter_i (
        .clk             (clk),
        .reset_i         (reset_i),
        .switch_request_i(switch_request),
        .xbar_ready_i    (xbar_ready_i),
        .vc_sel_o        (vc_sel),
        .valid_sel_o     (valid_sel)
    );

    // a switch grant is the crossbar's valid.
    assign flit_valid_o = valid_sel;

endmodule

`default_nettype wire

// File: sim/tb_router_input_stage.sv
`timescale 1ns/1ps
`default_nettype none
`include "noc_defines.svh"

module tb_router_input_stage;

    // cycles any single wait may take before it is called stuck.
    localparam int STEP_LIMIT = 50;
    localparam int ALL_VCS    = (1 << `NOC_VC_NUM) - 1;

    logic                                   clk;
    logic                                   reset_i;
    noc_flit_pkg::flit_t                    data_i;
    logic                                   valid_flit_i;
    logic [`NOC_VC_NUM-1:0]                 vc_valid_i;
    noc_flit_pkg::vc_id_t [`NOC_VC_NUM-1:0] vc_new_i;
    logic                                   xbar_ready_i;
    noc_flit_pkg::flit_t                    flit_o;
    logic                                   flit_valid_o;
    noc_route_pkg::port_t                   out_port_o;
    logic [`NOC_VC_NUM-1:0]                 vc_request_o;
    logic [`NOC_VC_NUM-1:0]                 on_off_o;
    logic [`NOC_VC_NUM-1:0]                 is_full_o;
    logic [`NOC_VC_NUM-1:0]                 is_empty_o;
    logic [`NOC_VC_NUM-1:0]                 error_o;

    int value_errors;
    int other_errors;
    int seed;
    int stall_max;

    // node sits at x 1, y 2 of the mesh.
    router_input_stage #(
        .X_CURRENT(1),
        .Y_CURRENT(2)
    ) dut_i (
        .clk         (clk),
        .reset_i     (reset_i),
        .data_i      (data_i),
        .valid_flit_i(valid_flit_i),
        .vc_valid_i  (vc_valid_i),
        .vc_new_i    (vc_new_i),
        .xbar_ready_i(xbar_ready_i),
        .flit_o      (flit_o),
        .flit_valid_o(flit_valid_o),
        .out_port_o  (out_port_o),
        .vc_request_o(vc_request_o),
        .on_off_o    (on_off_o),
        .is_full_o   (is_full_o),
        .is_empty_o  (is_empty_o),
        .error_o     (error_o)
    );

    always #2 clk = ~clk;

    function automatic logic [2*`NOC_COORD_W+`NOC_PAYLOAD_W-1:0] pack_data(
        input int x, input int y, input int payload);
        return {`NOC_COORD_W'(x), `NOC_COORD_W'(y), `NOC_PAYLOAD_W'(payload)};
    endfunction

    task automatic compare_value(input string name, input int expected, input int actual);
        assert (expected == actual)
        else
        begin
            value_errors++;
            $display("ERR %0t %s expected %0h actual %0h", $time, name, expected, actual);
        end
    endtask

    task automatic ensure(input logic cond, input string what);
        assert (cond)
        else
        begin
            other_errors++;
            $display("%0t %s", $time, what);
        end
    endtask

    task automatic send_flit(input int vc, input int label, input int x, input int y,
                             input int payload);
        data_i.flit_label = noc_flit_pkg::flit_label_t'(label);
        data_i.vc_id      = noc_flit_pkg::vc_id_t'(vc);
        data_i.data.raw   = pack_data(x, y, payload);
        valid_flit_i      = 1'b1;
        @(negedge clk);
        valid_flit_i = 1'b0;
    endtask

    // answer the allocator request of one VC.
    task automatic grant_vc(input int vc, input int new_vc);
        int cycles;
        cycles = 0;
        while (!vc_request_o[vc] && cycles < STEP_LIMIT)
        begin
            @(negedge clk);
            cycles++;
        end
        ensure(vc_request_o[vc], "no VC request came for a VC that was to be granted");
        vc_new_i[vc]   = noc_flit_pkg::vc_id_t'(new_vc);
        vc_valid_i[vc] = 1'b1;
        @(negedge clk);
        vc_valid_i[vc] = 1'b0;
    endtask

    // crossbar is ready only while a flit is expected.
    task automatic expect_flit(input int port, input int vc, input int label, input int x,
                               input int y, input int payload);
        int   stall;
        int   cycles;
        logic got;
        stall = int'($unsigned($random(seed)) % (stall_max + 1));
        xbar_ready_i = 1'b0;
        for (int i = 0; i < stall; i++)
        begin
            #1;
            ensure(!flit_valid_o, "a flit went out while the crossbar was not ready");
            @(negedge clk);
        end
        xbar_ready_i = 1'b1;
        got    = 1'b0;
        cycles = 0;
        while (!got && cycles < STEP_LIMIT)
        begin
            #1;
            if (flit_valid_o)
            begin
                got = 1'b1;
                compare_value("out_port_o", port, int'(out_port_o));
                compare_value("flit_o.vc_id", vc, int'(flit_o.vc_id));
                compare_value("flit_o.flit_label", label, int'(flit_o.flit_label));
                compare_value("flit_o.data", int'(pack_data(x, y, payload)),
                              int'(flit_o.data.raw));
            end
            @(negedge clk);
            cycles++;
        end
        xbar_ready_i = 1'b0;
        ensure(got, "timed out waiting for an expected flit");
    endtask

    task automatic verify_status(input int vc, input int full, input int on_off, input int err);
        compare_value($sformatf("is_full_o[%0d]", vc), full, int'(is_full_o[vc]));
        compare_value($sformatf("on_off_o[%0d]", vc), on_off, int'(on_off_o[vc]));
        compare_value($sformatf("error_o[%0d]", vc), err, int'(error_o[vc]));
    endtask

    initial
    begin
        int    fd;
        int    n;
        string cmd;
        string line;
        int    arg [6];
        clk          = 1'b0;
        reset_i      = 1'b1;
        data_i       = '0;
        valid_flit_i = 1'b0;
        vc_valid_i   = '0;
        vc_new_i     = '0;
        xbar_ready_i = 1'b0;
        value_errors = 0;
        other_errors = 0;
        seed         = 32'h92c4;
        stall_max    = 0;
        repeat (5) @(negedge clk);
        reset_i = 1'b0;
        #1;
        compare_value("flit_valid_o", 0, int'(flit_valid_o));
        compare_value("vc_request_o", 0, int'(vc_request_o));
        compare_value("error_o", 0, int'(error_o));
        compare_value("on_off_o", ALL_VCS, int'(on_off_o));
        compare_value("is_empty_o", ALL_VCS, int'(is_empty_o));
        @(negedge clk);

        fd = $fopen("sim/tb_stim_input.txt", "r");
        if (fd == 0)
        begin
            other_errors++;
            $display("the stimulus file could not be opened");
        end
        else
        begin
            while ($fscanf(fd, "%s", cmd) == 1)
            begin
                if (cmd.substr(0, 0) == "#")
                    n = $fgets(line, fd);
                else if (cmd == "S")
                begin
                    n = $fscanf(fd, "%d %d %d %d %h", arg[0], arg[1], arg[2], arg[3], arg[4]);
                    ensure(n == 5, "a send line in the stimulus file is malformed");
                    send_flit(arg[0], arg[1], arg[2], arg[3], arg[4]);
                end
                else if (cmd == "G")
                begin
                    n = $fscanf(fd, "%d %d", arg[0], arg[1]);
                    ensure(n == 2, "a grant line in the stimulus file is malformed");
                    grant_vc(arg[0], arg[1]);
                end
                else if (cmd == "X")
                begin
                    n = $fscanf(fd, "%d", stall_max);
                    ensure(n == 1, "a crossbar line in the stimulus file is malformed");
                end
                else if (cmd == "E")
                begin
                    n = $fscanf(fd, "%d %d %d %d %d %h", arg[0], arg[1], arg[2], arg[3],
                                arg[4], arg[5]);
                    ensure(n == 6, "an expect line in the stimulus file is malformed");
                    expect_flit(arg[0], arg[1], arg[2], arg[3], arg[4], arg[5]);
                end
                else if (cmd == "K")
                begin
                    n = $fscanf(fd, "%d %d %d %d", arg[0], arg[1], arg[2], arg[3]);
                    ensure(n == 4, "a status line in the stimulus file is malformed");
                    verify_status(arg[0], arg[1], arg[2], arg[3]);
                end
                else
                    ensure(1'b0, "unknown command in the stimulus file");
            end
            $fclose(fd);
        end

        // everything sent has been drained by now.
        #1;
        compare_value("is_empty_o", ALL_VCS, int'(is_empty_o));
        compare_value("error_o", 0, int'(error_o));
        $display("value errors: %0d, other errors: %0d", value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim/tb_stim_input.txt
# S vc label x y payload | G vc new_vc | X max_stall | K vc is_full on_off error
# E port vc label x y payload; label 0=H 1=B 2=T 3=HT; port 0=L 1=N 2=S 3=E 4=W
# single packet on vc 0 heading east
S 0 0 3 0 a01
S 0 1 0 0 b02
S 0 2 0 0 c03
G 0 1
E 3 1 0 3 0 a01
E 3 1 1 0 0 b02
E 3 1 2 0 0 c03
# packets on both vcs with random crossbar stalls
X 3
S 0 0 0 2 101
S 1 0 1 0 201
S 0 2 0 0 102
S 1 2 0 0 202
G 0 1
G 1 0
E 1 0 0 1 0 201
E 4 1 0 0 2 101
E 1 0 2 0 0 202
E 4 1 2 0 0 102
# fill vc 0, then overflow it
S 0 0 1 2 301
S 0 1 0 0 302
S 0 1 0 0 303
K 0 0 0 0
S 0 2 0 0 304
K 0 1 0 0
S 0 1 0 0 3ff
K 0 1 0 1
G 0 0
E 0 0 0 1 2 301
E 0 0 1 0 0 302
E 0 0 1 0 0 303
E 0 0 2 0 0 304
# a tail frees vc 1 for a head that turns south
S 1 0 2 1 401
S 1 2 0 0 402
S 1 3 1 3 403
G 1 1
E 3 1 0 2 1 401
E 3 1 2 0 0 402
G 1 0
E 2 0 3 1 3 403

// File: router_input_stage.f
+incdir+logic
logic/noc_flit_pkg.sv
logic/noc_route_pkg.sv
logic/vc_buffer_if.sv
logic/route_compute.sv
logic/vc_buffer.sv
logic/switch_arbiter.sv
logic/input_port.sv
logic/router_input_stage.sv
sim/tb_router_input_stage.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_router_input_stage
FILELIST  ?= router_input_stage.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SRCS    := $(shell grep -v '^+' $(FILELIST))
HDRS    := $(wildcard logic/*.svh)
STIM    := sim/tb_stim_input.txt

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: $(SIM_BIN) $(STIM)
	-$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TB FAILED" $(LOG) || ! grep -q "TB PASSED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
